// ==== Bender.yml ====
package:
  name: warp

export_include_dirs:
  - design

sources:
  - files:
      - design/warpPkg.sv
      - design/busDecode.sv
      - design/fastRam.sv
      - design/ioBridge.sv
      - design/ioBusMaster.sv
      - design/cycleTimer.sv
      - design/fsbAck.sv
      - design/warpTop.sv
  - target: test
    files:
      - testbench/warp_props.sv
      - testbench/warpTb.sv

// ==== design/busDecode.sv ====
`timescale 1ns/10ps

module busDecode (
	input  logic               CLK_FSB,
	input  logic               rstN,
	input  warpPkg::fsbCycle_t cyc,
	input  logic               asN,
	output logic               bact,
	output warpPkg::region_e   region
);
	import warpPkg::*;

	region_e nextRegion;  // Address map result for the current pins

	// Address map, IACK space checked first
	always_comb begin
		if (cyc.addr[23:4] == '1)
			nextRegion = RegIack;
		else if (cyc.addr[23:20] == 4'hE)
			nextRegion = RegIo;
		else if (cyc.addr[23:22] == 2'b00)
			nextRegion = RegRam;
		else
			nextRegion = RegNone;
	end

	always_ff @(posedge CLK_FSB) begin
		if (!rstN) begin
			bact <= 1'b0;
			region <= RegNone;
		end else begin
			bact <= !asN;  // One clock behind the strobe
			// Capture target on the leading edge of the cycle
			if (!asN && !bact)
				region <= nextRegion;
		end
	end

endmodule

// ==== design/cycleTimer.sv ====
`timescale 1ns/10ps
`include "warp_defines.svh"

module cycleTimer (
	input  logic CLK_FSB,
	input  logic rstN,
	input  logic bact,
	input  logic cycEnd,      // Some acknowledge already out
	output logic berrTimeout
);
	localparam int CntBits = $clog2(`BERR_TIMEOUT + 1);

	logic [CntBits-1:0] cnt;
	logic running;

	// Stops once answered or timed out, so it saturates
	assign running = bact && !cycEnd && !berrTimeout;

	always_ff @(posedge CLK_FSB) begin
		if (!rstN) begin
			cnt <= '0;
			berrTimeout <= 1'b0;
		end else if (!bact) begin
			cnt <= '0;             // Cleared between cycles
			berrTimeout <= 1'b0;
		end else if (running) begin
			cnt <= cnt + 1'b1;
			if (cnt == CntBits'(`BERR_TIMEOUT - 1))
				berrTimeout <= 1'b1;
		end
	end

endmodule

// ==== design/fastRam.sv ====
`timescale 1ns/10ps
`include "warp_defines.svh"

module fastRam (
	input  logic               CLK_FSB,
	input  logic               rstN,
	input  logic               bact,
	input  warpPkg::region_e   region,
	input  warpPkg::fsbCycle_t cyc,
	output logic               ramReady,
	output logic [15:0]        ramRdata
);
	import warpPkg::*;

	localparam int RamWords = 2 ** `RAM_ADDR_BITS;
	localparam int WaitBits = $clog2(`RAM_WAIT + 1);

	logic [15:0] mem [RamWords];
	logic [WaitBits-1:0] waitCnt;
	logic ramSel;
	logic expire;                           // Last wait state of this cycle
	logic [`RAM_ADDR_BITS-1:0] wordIdx;

	assign ramSel = bact && (region == RegRam);
	assign expire = ramSel && !ramReady && (waitCnt == WaitBits'(`RAM_WAIT - 1));
	assign wordIdx = cyc.addr[`RAM_ADDR_BITS:1];  // High bits ignored, RAM aliases

	// Wait state counter, restarts with each RAM cycle
	always_ff @(posedge CLK_FSB) begin
		if (!rstN) begin
			waitCnt <= '0;
			ramReady <= 1'b0;
		end else if (!ramSel) begin
			waitCnt <= '0;
			ramReady <= 1'b0;
		end else if (expire) begin
			ramReady <= 1'b1;  // Held until bact drops
		end else if (!ramReady) begin
			waitCnt <= waitCnt + 1'b1;
		end
	end

	// Array and read port, once per cycle at expiry
	always_ff @(posedge CLK_FSB) begin
		if (expire) begin
			ramRdata <= mem[wordIdx];
			if (cyc.write && cyc.upper)
				mem[wordIdx][15:8] <= cyc.wdata[15:8];
			if (cyc.write && cyc.lower)
				mem[wordIdx][7:0] <= cyc.wdata[7:0];
		end
	end

endmodule

// ==== design/fsbAck.sv ====
`timescale 1ns/10ps

module fsbAck (
	input  logic             CLK_FSB,
	input  logic             rstN,
	input  logic             asN,
	input  logic             bact,
	input  warpPkg::region_e region,
	input  logic             ramReady,
	input  logic             ioReady,
	input  logic             ioBerr,
	input  logic             berrTimeout,
	output logic             dtackN,
	output logic             vpaN,
	output logic             berrN,
	output logic             cycEnd
);
	import warpPkg::*;

	assign cycEnd = !dtackN || !vpaN || !berrN;  // Any acknowledge low

	always_ff @(posedge CLK_FSB) begin
		if (!rstN) begin
			dtackN <= 1'b1;
			vpaN <= 1'b1;
			berrN <= 1'b1;
		end else if (asN) begin
			dtackN <= 1'b1;  // Strobe high, release all
			vpaN <= 1'b1;
			berrN <= 1'b1;
		end else if (bact && !cycEnd) begin
			// First answer wins and is latched until AS rises
			if (ioBerr || berrTimeout)
				berrN <= 1'b0;
			else if (region == RegIack)
				vpaN <= 1'b0;    // Autovector
			else if (ramReady || ioReady)
				dtackN <= 1'b0;
		end
	end

endmodule

// ==== design/ioBridge.sv ====
`timescale 1ns/10ps

module ioBridge (
	input  logic               CLK_FSB,
	input  logic               rstN,
	input  logic               bact,
	input  warpPkg::region_e   region,
	input  warpPkg::fsbCycle_t cyc,
	output logic               ioReady,
	output logic               ioBerr,
	output logic [15:0]        ioRdataOut,
	output logic               reqValid,
	output warpPkg::ioReq_t    req,
	input  logic               reqDone,
	input  warpPkg::ioResp_t   resp
);
	import warpPkg::*;

	typedef enum logic [1:0] {
		StIdle,  // Waiting for an I/O cycle or a free latch
		StRead,  // Read in the latch, master busy with it
		StDone   // CPU answered, wait for bact to fall
	} state_e;

	state_e state;
	logic ioSel;
	logic latchFree;
	logic accept;      // Cycle goes into the latch this clock
	ioReq_t cycReq;

	assign ioSel = bact && (region == RegIo);
	assign latchFree = !reqValid || reqDone;  // Empty, or emptied this clock
	assign accept = (state == StIdle) && ioSel && latchFree;
	assign cycReq = '{addr: cyc.addr, write: cyc.write, upper: cyc.upper,
		lower: cyc.lower, wdata: cyc.wdata};

	always_ff @(posedge CLK_FSB) begin
		if (!rstN) begin
			state <= StIdle;
			reqValid <= 1'b0;
			ioReady <= 1'b0;
			ioBerr <= 1'b0;
		end else begin
			if (reqDone)
				reqValid <= 1'b0;  // Master finished the latched request
			case (state)
				StIdle: begin
					if (accept) begin
						reqValid <= 1'b1;
						if (cyc.write) begin
							ioReady <= 1'b1;  // Posted, ack at once
							state <= StDone;
						end else begin
							state <= StRead;
						end
					end
				end
				StRead: begin
					if (reqDone && bact) begin
						ioReady <= !resp.berr;
						ioBerr <= resp.berr;
						state <= StDone;
					end else if (reqDone) begin
						state <= StIdle;   // CPU already left on timeout
					end
				end
				StDone: begin
					if (!bact) begin
						ioReady <= 1'b0;
						ioBerr <= 1'b0;
						state <= StIdle;
					end
				end
				default: state <= StIdle;
			endcase
		end
	end

	// Request latch and read data holding
	always_ff @(posedge CLK_FSB) begin
		if (accept)
			req <= cycReq;
		if (state == StRead && reqDone)
			ioRdataOut <= resp.rdata;
	end

endmodule

// ==== design/ioBusMaster.sv ====
`timescale 1ns/10ps

module ioBusMaster (
	input  logic             CLK_FSB,
	input  logic             rstN,
	input  logic             reqValid,
	input  warpPkg::ioReq_t  req,
	output logic             reqDone,
	output warpPkg::ioResp_t resp,
	output logic [23:1]      ioAddr,
	output logic             ioAsN,
	output logic             ioUdsN,
	output logic             ioLdsN,
	output logic             ioWeN,
	output logic [15:0]      ioWdata,
	input  logic [15:0]      ioRdata,
	input  logic             ioDtackN,
	input  logic             ioBerrN
);

	typedef enum logic [1:0] {
		StIdle,     // Bus free
		StStrobe,   // Strobes low, waiting for the device
		StRelease   // Strobes high, device still answering
	} state_e;

	state_e state;
	logic devAnswer;
	logic start;      // New bus cycle this clock
	logic finish;     // Device answer sampled this clock

	assign devAnswer = !ioDtackN || !ioBerrN;
	assign start = (state == StIdle) && reqValid && !devAnswer;
	assign finish = (state == StStrobe) && devAnswer;

	always_ff @(posedge CLK_FSB) begin
		if (!rstN) begin
			state <= StIdle;
			ioAsN <= 1'b1;
			ioUdsN <= 1'b1;
			ioLdsN <= 1'b1;
			ioWeN <= 1'b1;
			reqDone <= 1'b0;
		end else begin
			reqDone <= finish;  // Single clock pulse
			case (state)
				StIdle: begin
					if (start) begin
						ioAsN <= 1'b0;
						ioUdsN <= !req.upper;
						ioLdsN <= !req.lower;
						ioWeN <= !req.write;
						state <= StStrobe;
					end
				end
				StStrobe: begin
					if (finish) begin
						ioAsN <= 1'b1;
						ioUdsN <= 1'b1;
						ioLdsN <= 1'b1;
						state <= StRelease;
					end
				end
				StRelease: begin
					// No new strobe while DTACK/BERR still low
					if (!devAnswer)
						state <= StIdle;
				end
				default: state <= StIdle;
			endcase
		end
	end

	// Address, write data and response registers
	always_ff @(posedge CLK_FSB) begin
		if (start) begin
			ioAddr <= req.addr;
			ioWdata <= req.wdata;
		end
		if (finish)
			resp <= '{rdata: ioRdata, berr: !ioBerrN};  // BERR wins over data
	end

endmodule

// ==== design/warpPkg.sv ====
package warpPkg;

	// Decoded target of an FSB cycle
	typedef enum logic [1:0] {
		RegRam  = 2'd0,  // A23:22 zero
		RegIo   = 2'd1,  // A23:20 hex E
		RegIack = 2'd2,  // A23:4 all ones
		RegNone = 2'd3   // Unmapped, ends by timeout
	} region_e;

	// CPU cycle as seen on the FSB pins, lanes active high
	typedef struct packed {
		logic [23:1] addr;   // Word address, no A0 on the 68000
		logic        write;
		logic        upper;  // D15:8 lane
		logic        lower;  // D7:0 lane
		logic [15:0] wdata;
	} fsbCycle_t;

	// Latched request toward the I/O master
	typedef struct packed {
		logic [23:1] addr;
		logic        write;
		logic        upper;
		logic        lower;
		logic [15:0] wdata;
	} ioReq_t;

	// Answer from the I/O master
	typedef struct packed {
		logic [15:0] rdata;
		logic        berr;   // Device ended with BERR
	} ioResp_t;

endpackage

// ==== design/warpTop.sv ====
`timescale 1ns/10ps

module warpTop (
	input  logic        CLK_FSB,
	input  logic        rstN,
	// CPU front-side bus
	input  logic [23:1] addr,
	input  logic        asN,
	input  logic        udsN,
	input  logic        ldsN,
	input  logic        weN,
	input  logic [15:0] wdata,
	output logic [15:0] rdata,
	output logic        dtackN,
	output logic        vpaN,
	output logic        berrN,
	// Slow I/O bus
	output logic [23:1] ioAddr,
	output logic        ioAsN,
	output logic        ioUdsN,
	output logic        ioLdsN,
	output logic        ioWeN,
	output logic [15:0] ioWdata,
	input  logic [15:0] ioRdata,
	input  logic        ioDtackN,
	input  logic        ioBerrN
);
	import warpPkg::*;

	fsbCycle_t cyc;
	logic bact;
	region_e region;
	logic ramReady;
	logic [15:0] ramRdata;
	logic ioReady, ioBerr;
	logic [15:0] ioRdataOut;
	logic reqValid, reqDone;
	ioReq_t req;
	ioResp_t resp;
	logic berrTimeout;
	logic cycEnd;

	// Pins to cycle, strobes and WE flipped to active high
	assign cyc = '{addr: addr, write: !weN, upper: !udsN, lower: !ldsN, wdata: wdata};

	// Read data path picked by the decoded region
	assign rdata = (region == RegRam) ? ramRdata : ioRdataOut;

	busDecode decode (
		.CLK_FSB(CLK_FSB), .rstN(rstN), .cyc(cyc), .asN(asN),
		.bact(bact), .region(region));

	fastRam ram (
		.CLK_FSB(CLK_FSB), .rstN(rstN), .bact(bact), .region(region), .cyc(cyc),
		.ramReady(ramReady), .ramRdata(ramRdata));

	// I/O slave side, one-entry posted write latch
	ioBridge iobs (
		.CLK_FSB(CLK_FSB), .rstN(rstN), .bact(bact), .region(region), .cyc(cyc),
		.ioReady(ioReady), .ioBerr(ioBerr), .ioRdataOut(ioRdataOut),
		.reqValid(reqValid), .req(req), .reqDone(reqDone), .resp(resp));

	// I/O master side, strobe and acknowledge toward devices
	ioBusMaster iobm (
		.CLK_FSB(CLK_FSB), .rstN(rstN), .reqValid(reqValid), .req(req),
		.reqDone(reqDone), .resp(resp),
		.ioAddr(ioAddr), .ioAsN(ioAsN), .ioUdsN(ioUdsN), .ioLdsN(ioLdsN),
		.ioWeN(ioWeN), .ioWdata(ioWdata), .ioRdata(ioRdata),
		.ioDtackN(ioDtackN), .ioBerrN(ioBerrN));

	cycleTimer cnt (
		.CLK_FSB(CLK_FSB), .rstN(rstN), .bact(bact), .cycEnd(cycEnd),
		.berrTimeout(berrTimeout));

	fsbAck fsb (
		.CLK_FSB(CLK_FSB), .rstN(rstN), .asN(asN), .bact(bact), .region(region),
		.ramReady(ramReady), .ioReady(ioReady), .ioBerr(ioBerr),
		.berrTimeout(berrTimeout),
		.dtackN(dtackN), .vpaN(vpaN), .berrN(berrN), .cycEnd(cycEnd));

endmodule

// ==== design/warp_defines.svh ====
`ifndef WARP_DEFINES_SVH
`define WARP_DEFINES_SVH

// Local RAM word-address width
// RAM aliases across its region above this
`define RAM_ADDR_BITS 10

// Clocks from bact to RAM ready
`define RAM_WAIT 2

// Clocks of an unanswered active cycle before BERR
// Also catches an I/O device that never answers
`define BERR_TIMEOUT 64

`endif

// ==== flist.f ====
+incdir+design
design/warpPkg.sv
design/busDecode.sv
design/fastRam.sv
design/ioBridge.sv
design/ioBusMaster.sv
design/cycleTimer.sv
design/fsbAck.sv
design/warpTop.sv
testbench/warp_props.sv
testbench/warpTb.sv

// ==== testbench/warpTb.sv ====
`timescale 1ns/10ps
`include "warp_defines.svh"

module warpTb;

	typedef enum logic [1:0] {AckDtack, AckVpa, AckBerr} ack_e;

	// One CPU cycle of the table, byte address as on a memory map
	typedef struct packed {
		logic        write;
		logic [23:0] addr;
		logic        upper;
		logic        lower;
		logic [15:0] wdata;
		ack_e        expAck;
		logic        checkData;
	} op_t;

	localparam int NumOps = 24;
	localparam int RamWords = 2 ** `RAM_ADDR_BITS;

	logic CLK_FSB, rstN;
	logic [23:1] addr;
	logic asN, udsN, ldsN, weN;
	logic [15:0] wdata, rdata;
	logic dtackN, vpaN, berrN;
	logic [23:1] ioAddr;
	logic ioAsN, ioUdsN, ioLdsN, ioWeN;
	logic [15:0] ioWdata, ioRdata;
	logic ioDtackN, ioBerrN;

	op_t ops [NumOps];
	logic [15:0] ramShadow [RamWords];  // Expected RAM contents
	logic [15:0] ioShadow [256];        // Expected device contents
	logic [15:0] devMem [256];          // Device model storage
	logic [41:0] devLog [$];            // {write, addr, udsN, ldsN, data} seen by device
	logic [41:0] expLog [$];
	int errors = 0;
	int checks = 0;

	warpTop i_dut (.*);

	initial begin
		CLK_FSB = 1'b0;
		forever #50 CLK_FSB = ~CLK_FSB;
	end

	initial begin
		#(NumOps * (`BERR_TIMEOUT + 20) * 100);
		$display("Watchdog expired, the table did not finish in time");
		$display("tests failed");
		$finish;
	end

	// Power-up contents, depends on every index bit
	function automatic logic [15:0] fillWord(input logic [7:0] idx);
		fillWord = {idx ^ 8'h5A, ~idx};
	endfunction

	function automatic logic [15:0] mergeLanes(input logic [15:0] old, input logic [15:0] wr,
		input logic upper, input logic lower);
		mergeLanes = old;
		if (upper)
			mergeLanes[15:8] = wr[15:8];
		if (lower)
			mergeLanes[7:0] = wr[7:0];
	endfunction

	task automatic checkValue(input string name, input logic [63:0] exp, input logic [63:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic loadTable();
		// write, byte addr, upper, lower, wdata, outcome, check rdata
		ops[0] = '{1'b1, 24'h000010, 1'b1, 1'b1, 16'h1234, AckDtack, 1'b0};
		ops[1] = '{1'b0, 24'h000010, 1'b1, 1'b1, 16'h0000, AckDtack, 1'b1};
		ops[2] = '{1'b1, 24'h000010, 1'b1, 1'b0, 16'hAB00, AckDtack, 1'b0};
		ops[3] = '{1'b1, 24'h000010, 1'b0, 1'b1, 16'h00CD, AckDtack, 1'b0};
		ops[4] = '{1'b0, 24'h000010, 1'b1, 1'b1, 16'h0000, AckDtack, 1'b1};
		ops[5] = '{1'b1, 24'h000810, 1'b1, 1'b1, 16'h5A5A, AckDtack, 1'b0};  // Alias of 000010
		ops[6] = '{1'b0, 24'h000010, 1'b1, 1'b1, 16'h0000, AckDtack, 1'b1};
		ops[7] = '{1'b0, 24'h3FF810, 1'b1, 1'b1, 16'h0000, AckDtack, 1'b1};
		ops[8] = '{1'b1, 24'hE00020, 1'b1, 1'b1, 16'hC0DE, AckDtack, 1'b0};  // Posted
		ops[9] = '{1'b0, 24'hE00020, 1'b1, 1'b1, 16'h0000, AckDtack, 1'b1};
		ops[10] = '{1'b1, 24'hE00040, 1'b1, 1'b1, 16'h1111, AckDtack, 1'b0}; // Back to back
		ops[11] = '{1'b1, 24'hE00042, 1'b1, 1'b1, 16'h2222, AckDtack, 1'b0};
		ops[12] = '{1'b1, 24'hE00044, 1'b0, 1'b1, 16'h0033, AckDtack, 1'b0};
		ops[13] = '{1'b1, 24'hE00046, 1'b1, 1'b0, 16'h4400, AckDtack, 1'b0};
		ops[14] = '{1'b0, 24'hE00040, 1'b1, 1'b1, 16'h0000, AckDtack, 1'b1};
		ops[15] = '{1'b0, 24'hE00044, 1'b1, 1'b1, 16'h0000, AckDtack, 1'b1};
		ops[16] = '{1'b0, 24'hE001FE, 1'b1, 1'b1, 16'h0000, AckBerr, 1'b0};  // Index FF faults
		ops[17] = '{1'b0, 24'hE00046, 1'b1, 1'b1, 16'h0000, AckDtack, 1'b1};
		ops[18] = '{1'b0, 24'h800000, 1'b1, 1'b1, 16'h0000, AckBerr, 1'b0};  // Unmapped
		ops[19] = '{1'b1, 24'h400000, 1'b1, 1'b1, 16'hDEAD, AckBerr, 1'b0};
		ops[20] = '{1'b0, 24'hFFFFF4, 1'b0, 1'b1, 16'h0000, AckVpa, 1'b0};   // IACK level 2
		ops[21] = '{1'b0, 24'h000010, 1'b1, 1'b1, 16'h0000, AckDtack, 1'b1};
		ops[22] = '{1'b1, 24'hE00050, 1'b1, 1'b1, 16'hBEEF, AckDtack, 1'b0};
		ops[23] = '{1'b0, 24'hE00050, 1'b1, 1'b1, 16'h0000, AckDtack, 1'b1};
	endtask

	// One CPU bus cycle, strobe held until an acknowledge shows
	task automatic runCycle(input op_t op, output logic [2:0] acks, output logic [15:0] data,
		output int clks);
		@(posedge CLK_FSB);
		#10;
		addr = op.addr[23:1];
		weN = !op.write;
		udsN = !op.upper;
		ldsN = !op.lower;
		wdata = op.wdata;
		asN = 1'b0;
		clks = 0;
		do begin
			@(posedge CLK_FSB);
			#10;
			clks++;
		end while (dtackN && vpaN && berrN);
		acks = {dtackN, vpaN, berrN};
		data = rdata;
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		do begin
			@(posedge CLK_FSB);
			#10;
		end while (!(dtackN && vpaN && berrN));  // Wait for the release
	endtask

	// Slow I/O device, answers 1 to 8 clocks after the strobe
	initial begin
		int delay;
		logic [7:0] idx;
		void'($urandom(32'hdb2b));  // Seed for the answer delays
		ioDtackN = 1'b1;
		ioBerrN = 1'b1;
		ioRdata = '0;
		for (int i = 0; i < 256; i++)
			devMem[i] = fillWord(i[7:0]);
		forever begin
			@(posedge CLK_FSB);
			#10;
			if (rstN && !ioAsN) begin
				delay = $urandom_range(8, 1);
				repeat (delay) begin
					@(posedge CLK_FSB);
					#10;
				end
				idx = ioAddr[8:1];
				devLog.push_back({!ioWeN, ioAddr, ioUdsN, ioLdsN, ioWeN ? 16'h0000 : ioWdata});
				if (idx == 8'hFF) begin
					ioBerrN = 1'b0;  // Faulting register
				end else begin
					if (!ioWeN)
						devMem[idx] = mergeLanes(devMem[idx], ioWdata, !ioUdsN, !ioLdsN);
					ioRdata = devMem[idx];
					ioDtackN = 1'b0;
				end
				do begin
					@(posedge CLK_FSB);
					#10;
				end while (!ioAsN);
				ioDtackN = 1'b1;
				ioBerrN = 1'b1;
			end
		end
	end

	initial begin
		op_t op;
		logic [2:0] acks;
		logic [15:0] data;
		logic [15:0] expData;
		logic [`RAM_ADDR_BITS-1:0] ramIdx;
		logic [7:0] ioIdx;
		logic isIo;
		int clks;
		int assertFails;
		rstN = 1'b0;
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		weN = 1'b1;
		addr = '0;
		wdata = '0;
		for (int i = 0; i < 256; i++)
			ioShadow[i] = fillWord(i[7:0]);
		loadTable();
		repeat (10) @(posedge CLK_FSB);
		#10;
		rstN = 1'b1;
		for (int n = 0; n < NumOps; n++) begin
			op = ops[n];
			isIo = (op.addr[23:20] == 4'hE);
			ramIdx = op.addr[`RAM_ADDR_BITS:1];  // Aliased word index
			ioIdx = op.addr[8:1];
			expData = isIo ? ioShadow[ioIdx] : ramShadow[ramIdx];
			runCycle(op, acks, data, clks);
			checkValue("dtackN", op.expAck != AckDtack, acks[2]);
			checkValue("vpaN", op.expAck != AckVpa, acks[1]);
			checkValue("berrN", op.expAck != AckBerr, acks[0]);
			if (op.checkData)
				checkValue("rdata", expData, data);
			if (op.expAck == AckBerr && !isIo) begin
				checks++;
				if (clks < `BERR_TIMEOUT) begin
					errors++;
					$display("Bus error on entry %0d came after only %0d clocks", n, clks);
				end
			end
			if (op.write && op.expAck == AckDtack) begin
				if (isIo)
					ioShadow[ioIdx] = mergeLanes(ioShadow[ioIdx], op.wdata, op.upper, op.lower);
				else
					ramShadow[ramIdx] = mergeLanes(ramShadow[ramIdx], op.wdata, op.upper, op.lower);
			end
			if (isIo)
				expLog.push_back({op.write, op.addr[23:1], !op.upper, !op.lower,
					op.write ? op.wdata : 16'h0000});
		end
		while (devLog.size() < expLog.size())
			@(posedge CLK_FSB);  // Last posted write drains
		checkValue("devLog size", expLog.size(), devLog.size());
		for (int i = 0; i < expLog.size() && i < devLog.size(); i++)
			checkValue($sformatf("devLog[%0d]", i), expLog[i], devLog[i]);
		assertFails = i_dut.props.failCount;
		$display("Checks: %0d, check errors: %0d, assertion failures: %0d",
			checks, errors, assertFails);
		if (errors == 0 && assertFails == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== testbench/warp_props.sv ====
`timescale 1ns/10ps

module warpProps (
	input logic        CLK_FSB,
	input logic        rstN,
	input logic        asN,
	input logic        dtackN,
	input logic        vpaN,
	input logic        berrN,
	input logic [23:1] ioAddr,
	input logic        ioAsN,
	input logic        ioUdsN,
	input logic        ioLdsN,
	input logic        ioWeN,
	input logic [15:0] ioWdata
);
	int failCount = 0;  // Assertion failures so far

	// At most one FSB acknowledge low at a time
	oneAck: assert property (@(posedge CLK_FSB) disable iff (!rstN)
		$countones({!dtackN, !vpaN, !berrN}) <= 1)
		else begin
			failCount++;
			$error("more than one FSB acknowledge low");
		end

	// Strobe seen high, all acknowledges released on the next clock
	ackRelease: assert property (@(posedge CLK_FSB) disable iff (!rstN)
		asN |=> (dtackN && vpaN && berrN))
		else begin
			failCount++;
			$error("FSB acknowledge held after AS rose");
		end

	// I/O master keeps its pins still during a strobe
	ioStable: assert property (@(posedge CLK_FSB) disable iff (!rstN)
		(!ioAsN && !$past(ioAsN)) |-> $stable({ioAddr, ioUdsN, ioLdsN, ioWeN, ioWdata}))
		else begin
			failCount++;
			$error("I/O bus outputs changed while ioAsN low");
		end

endmodule

bind warpTop warpProps props (
	.CLK_FSB(CLK_FSB), .rstN(rstN), .asN(asN),
	.dtackN(dtackN), .vpaN(vpaN), .berrN(berrN),
	.ioAddr(ioAddr), .ioAsN(ioAsN), .ioUdsN(ioUdsN), .ioLdsN(ioLdsN),
	.ioWeN(ioWeN), .ioWdata(ioWdata));
